// File: design/fanPkg.sv
// fan controller package with register map constants and the shared register word layout
package fanPkg;

  // block identification code in the top half of register 0
  localparam logic [15:0] fanCsrId = 16'h00f5;

  // register address width with room for up to 255 fans after the id word
  localparam int CsrAddrWidth = 8;

  // the phase counter runs 0..99 and a duty of 100 is full on
  localparam int DutyMax = 100;
  localparam int PwmSteps = 100;

  // phase step rate in Hz for a 25 kHz PWM of 100 steps
  localparam int PrescaleRate = 2_500_000;

  // width of one tach pulse count
  localparam int PulseCountWidth = 10;

  // one register word seen either as the id word or as a fan word
  typedef union packed {
    struct packed {
      logic [15:0] csrId;
      logic [7:0]  reserved;
      logic [7:0]  fanCount;
    } idView;
    struct packed {
      logic [5:0]                 reservedHigh;
      logic [PulseCountWidth-1:0] pulsesPerWindow;
      logic [8:0]                 reservedLow;
      logic [6:0]                 dutyCycle;
    } fanView;
  } fanCsrWord_u;

endpackage

// File: design/fanTimebase.sv
// shared fan timebase with clock prescaler, PWM phase counter and tach window marker
`timescale 1ns/1ps

module fanTimebase #(
  parameter int ClockHz = 100_000_000,
  parameter int TachWindowPeriods =
    ClockHz / (fanPkg::PwmSteps * (ClockHz / fanPkg::PrescaleRate))
) (
  input  logic       clock,
  input  logic       rstN,
  output logic [6:0] phaseCount,
  output logic       windowPulse
);

  localparam int PrescaleDivider = ClockHz / fanPkg::PrescaleRate;
  // one extra bit keeps the width legal for a divider of 1
  localparam int PrescaleWidth = $clog2(PrescaleDivider) + 1;
  localparam int WindowWidth = $clog2(TachWindowPeriods + 1);

  logic [PrescaleWidth-1:0] prescaleCount;
  logic                     prescalePulse;
  logic                     phaseWrap;
  logic [WindowWidth-1:0]   windowCount;
  logic                     windowLast;

  assign prescalePulse = (prescaleCount == PrescaleWidth'(PrescaleDivider - 1));
  assign phaseWrap = prescalePulse && (phaseCount == 7'(fanPkg::PwmSteps - 1));
  assign windowLast = (windowCount == WindowWidth'(TachWindowPeriods - 1));

  always_ff @(posedge clock) begin
    if (!rstN) begin
      prescaleCount <= '0;
      phaseCount <= '0;
      windowCount <= '0;
      windowPulse <= 1'b0;
    end else begin
      // divide down to the phase step rate
      if (prescalePulse) begin
        prescaleCount <= '0;
      end else begin
        prescaleCount <= prescaleCount + 1'b1;
      end

      // phase steps 0..99 with one PWM period per wrap
      if (phaseWrap) begin
        phaseCount <= '0;
      end else if (prescalePulse) begin
        phaseCount <= phaseCount + 7'd1;
      end

      // count whole PWM periods to mark each measurement window
      windowPulse <= phaseWrap && windowLast;
      if (phaseWrap) begin
        windowCount <= windowLast ? '0 : windowCount + 1'b1;
      end
    end
  end

endmodule

// File: design/fanDebounce.sv
// tach input synchronizer and stable-level debouncer for one fan
`timescale 1ns/1ps

module fanDebounce #(
  parameter int SyncCycles = 3,
  parameter int DebounceCycles = 5
) (
  input  logic clock,
  input  logic rstN,
  input  logic rawIn,
  output logic cleanOut
);

  localparam int StableWidth = $clog2(DebounceCycles + 1);

  logic [SyncCycles-1:0]  syncChain;
  logic                   syncOut;
  logic [StableWidth-1:0] stableCount;

  assign syncOut = syncChain[SyncCycles-1];

  always_ff @(posedge clock) begin
    if (!rstN) begin
      syncChain <= '0;
      stableCount <= '0;
      cleanOut <= 1'b0;
    end else begin
      // shift the asynchronous input through the flop chain
      syncChain <= {syncChain[SyncCycles-2:0], rawIn};

      // a new level must hold for DebounceCycles before it is taken
      if (syncOut == cleanOut) begin
        stableCount <= '0;
      end else if (stableCount == StableWidth'(DebounceCycles - 1)) begin
        stableCount <= '0;
        cleanOut <= syncOut;
      end else begin
        stableCount <= stableCount + 1'b1;
      end
    end
  end

endmodule

// File: design/fanChannel.sv
// one fan channel with PWM output, tach edge detection and per-window pulse count
`timescale 1ns/1ps

module fanChannel #(
  parameter int SyncCycles = 3,
  parameter int DebounceCycles = 5
) (
  input  logic       clock,
  input  logic       rstN,
  input  logic [6:0] dutyCycle,
  input  logic [6:0] phaseCount,
  input  logic       windowPulse,
  input  logic       fanSense,
  output logic       fanPwm,
  output logic [fanPkg::PulseCountWidth-1:0] pulsesLastWindow
);

  logic                               senseClean;
  logic                               senseCleanQ;
  logic                               senseRise;
  logic [fanPkg::PulseCountWidth-1:0] pulsesThisWindow;

  fanDebounce #(
    .SyncCycles(SyncCycles),
    .DebounceCycles(DebounceCycles)
  ) fanDebounce_inst (
    .clock(clock),
    .rstN(rstN),
    .rawIn(fanSense),
    .cleanOut(senseClean)
  );

  assign senseRise = senseClean && !senseCleanQ;

  always_ff @(posedge clock) begin
    if (!rstN) begin
      // fans run flat out while the controller is in reset
      fanPwm <= 1'b1;
      senseCleanQ <= 1'b0;
      pulsesThisWindow <= '0;
      pulsesLastWindow <= '0;
    end else begin
      // any duty of 100 or more is above every phase
      fanPwm <= (dutyCycle > phaseCount);
      senseCleanQ <= senseClean;
      if (windowPulse) begin
        // an edge on the boundary cycle belongs to the next window
        pulsesLastWindow <= pulsesThisWindow;
        pulsesThisWindow <= {{(fanPkg::PulseCountWidth-1){1'b0}}, senseRise};
      end else if (senseRise) begin
        pulsesThisWindow <= pulsesThisWindow + 1'b1;
      end
    end
  end

endmodule

// File: design/fanRegisters.sv
// fan register file with duty registers, id word and a registered read mux over tach counts
`timescale 1ns/1ps

module fanRegisters #(
  parameter int FanCount = 1,
  parameter int FanDefaultDuty = 50
) (
  input  logic                                           clock,
  input  logic                                           rstN,
  input  logic                                           csrWrite,
  input  logic                                           csrRead,
  input  logic [fanPkg::CsrAddrWidth-1:0]                csrAddress,
  input  logic [31:0]                                    csrWriteData,
  input  logic [FanCount-1:0][fanPkg::PulseCountWidth-1:0] pulsesLastWindow,
  output logic [FanCount-1:0][6:0]                       dutyCycles,
  output fanPkg::fanCsrWord_u                            csrReadData,
  output logic                                           csrReadValid
);

  fanPkg::fanCsrWord_u writeWord;
  fanPkg::fanCsrWord_u readWord;

  assign writeWord = csrWriteData;

  // duty registers where only the duty field of a fan word is writable
  always_ff @(posedge clock) begin
    if (!rstN) begin
      for (int i = 0; i < FanCount; i++) begin
        dutyCycles[i] <= 7'(FanDefaultDuty);
      end
    end else if (csrWrite) begin
      for (int i = 0; i < FanCount; i++) begin
        if (csrAddress == fanPkg::CsrAddrWidth'(i + 1)) begin
          dutyCycles[i] <= writeWord.fanView.dutyCycle;
        end
      end
    end
  end

  // read decode where unmapped bits and addresses read as zero
  always_comb begin
    readWord = '0;
    if (csrAddress == '0) begin
      readWord.idView.csrId = fanPkg::fanCsrId;
      readWord.idView.fanCount = 8'(FanCount);
    end else begin
      for (int i = 0; i < FanCount; i++) begin
        if (csrAddress == fanPkg::CsrAddrWidth'(i + 1)) begin
          readWord.fanView.dutyCycle = dutyCycles[i];
          readWord.fanView.pulsesPerWindow = pulsesLastWindow[i];
        end
      end
    end
  end

  // response lands one cycle after the read strobe
  always_ff @(posedge clock) begin
    if (!rstN) begin
      csrReadValid <= 1'b0;
    end else begin
      csrReadValid <= csrRead;
    end
  end

  always_ff @(posedge clock) begin
    if (csrRead) begin
      csrReadData <= readWord;
    end
  end

endmodule

// File: design/fanController.sv
// multi-fan controller top with a shared timebase, register file and one channel per fan
`timescale 1ns/1ps

module fanController #(
  parameter int ClockHz = 100_000_000,
  parameter int FanCount = 1,
  parameter int FanDefaultDuty = 50,
  parameter int DebounceCycles = 5,
  parameter int SyncCycles = 3,
  parameter int TachWindowPeriods =
    ClockHz / (fanPkg::PwmSteps * (ClockHz / fanPkg::PrescaleRate))
) (
  input  logic                            clock,
  input  logic                            rstN,
  input  logic                            csrWrite,
  input  logic                            csrRead,
  input  logic [fanPkg::CsrAddrWidth-1:0] csrAddress,
  input  logic [31:0]                     csrWriteData,
  output fanPkg::fanCsrWord_u             csrReadData,
  output logic                            csrReadValid,
  input  logic [FanCount-1:0]             fanSense,
  output logic [FanCount-1:0]             fanPwm
);

  logic [6:0]                                       phaseCount;
  logic                                             windowPulse;
  logic [FanCount-1:0][6:0]                         dutyCycles;
  logic [FanCount-1:0][fanPkg::PulseCountWidth-1:0] pulsesLastWindow;

  fanTimebase #(
    .ClockHz(ClockHz),
    .TachWindowPeriods(TachWindowPeriods)
  ) fanTimebase_inst (
    .clock(clock),
    .rstN(rstN),
    .phaseCount(phaseCount),
    .windowPulse(windowPulse)
  );

  fanRegisters #(
    .FanCount(FanCount),
    .FanDefaultDuty(FanDefaultDuty)
  ) fanRegisters_inst (
    .clock(clock),
    .rstN(rstN),
    .csrWrite(csrWrite),
    .csrRead(csrRead),
    .csrAddress(csrAddress),
    .csrWriteData(csrWriteData),
    .pulsesLastWindow(pulsesLastWindow),
    .dutyCycles(dutyCycles),
    .csrReadData(csrReadData),
    .csrReadValid(csrReadValid)
  );

  // one channel per fan on the same phase and window
  for (genvar i = 0; i < FanCount; i++) begin : genChannel
    fanChannel #(
      .SyncCycles(SyncCycles),
      .DebounceCycles(DebounceCycles)
    ) fanChannel_inst (
      .clock(clock),
      .rstN(rstN),
      .dutyCycle(dutyCycles[i]),
      .phaseCount(phaseCount),
      .windowPulse(windowPulse),
      .fanSense(fanSense[i]),
      .fanPwm(fanPwm[i]),
      .pulsesLastWindow(pulsesLastWindow[i])
    );
  end

endmodule

// File: dv/fanControllerTb.sv
// fan controller testbench with directed register, PWM and tach counting tests
`timescale 1ns/1ps

module fanControllerTb;

  localparam int ClockHz = 5_000_000;
  localparam int FanCount = 2;
  localparam int FanDefaultDuty = 50;
  localparam int TachWindowPeriods = 20;
  // 2 clocks per phase step make 200 per PWM period and 4000 per window
  localparam int PrescaleDivider = ClockHz / fanPkg::PrescaleRate;
  localparam int PwmPeriodCycles = fanPkg::PwmSteps * PrescaleDivider;
  localparam int WindowCycles = TachWindowPeriods * PwmPeriodCycles;
  localparam int ReadTimeout = 20;

  logic                            clock = 1'b0;
  logic                            rstN;
  logic                            csrWrite;
  logic                            csrRead;
  logic [fanPkg::CsrAddrWidth-1:0] csrAddress;
  logic [31:0]                     csrWriteData;
  fanPkg::fanCsrWord_u             csrReadData;
  logic                            csrReadValid;
  logic [FanCount-1:0]             fanSense;
  logic [FanCount-1:0]             fanPwm;
  int                              errorCount;
  int                              timeoutCount;
  logic                            tachRunning;

  fanController #(
    .ClockHz(ClockHz),
    .FanCount(FanCount),
    .FanDefaultDuty(FanDefaultDuty),
    .DebounceCycles(5),
    .SyncCycles(3),
    .TachWindowPeriods(TachWindowPeriods)
  ) fanController_inst (
    .clock(clock),
    .rstN(rstN),
    .csrWrite(csrWrite),
    .csrRead(csrRead),
    .csrAddress(csrAddress),
    .csrWriteData(csrWriteData),
    .csrReadData(csrReadData),
    .csrReadValid(csrReadValid),
    .fanSense(fanSense),
    .fanPwm(fanPwm)
  );

  always #10 clock = ~clock;

  task automatic endRun();
    $display("summary: %0d errors, %0d timeouts", errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic reportTimeout(input string what);
    $display("timeout at %0t while waiting for %s", $time, what);
    timeoutCount++;
    endRun();
  endtask

  task automatic compareWord(input string name, input fanPkg::fanCsrWord_u actual,
                             input fanPkg::fanCsrWord_u expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %h, expected %h", $time, name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic compareCount(input string name,
                              input logic [fanPkg::PulseCountWidth-1:0] actual,
                              input logic [fanPkg::PulseCountWidth-1:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
      errorCount++;
    end
  endtask

  task automatic compareBit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %b, expected %b", $time, name, actual, expected);
      errorCount++;
    end
  endtask

  function automatic fanPkg::fanCsrWord_u makeFanWord(input logic [6:0] duty,
                                                      input logic [9:0] count);
    fanPkg::fanCsrWord_u word;
    word = '0;
    word.fanView.dutyCycle = duty;
    word.fanView.pulsesPerWindow = count;
    return word;
  endfunction

  function automatic fanPkg::fanCsrWord_u makeIdWord();
    fanPkg::fanCsrWord_u word;
    word = '0;
    word.idView.csrId = fanPkg::fanCsrId;
    word.idView.fanCount = 8'(FanCount);
    return word;
  endfunction

  task automatic csrWriteTask(input logic [7:0] address, input logic [31:0] data);
    @(negedge clock);
    csrWrite = 1'b1;
    csrAddress = address;
    csrWriteData = data;
    @(negedge clock);
    csrWrite = 1'b0;
  endtask

  task automatic csrReadTask(input logic [7:0] address, output fanPkg::fanCsrWord_u data);
    int waitCycles;
    @(negedge clock);
    csrRead = 1'b1;
    csrAddress = address;
    @(negedge clock);
    csrRead = 1'b0;
    waitCycles = 0;
    while (csrReadValid !== 1'b1) begin
      if (waitCycles == ReadTimeout) begin
        reportTimeout("csrReadValid");
      end
      @(negedge clock);
      waitCycles++;
    end
    data = csrReadData;
    // the response is a single-cycle pulse
    @(negedge clock);
    compareBit("csrReadValid one cycle after the response", csrReadValid, 1'b0);
  endtask

  // pulse train on one fan until tachRunning drops
  task automatic driveTach(input int fan, input int period, input int highCycles);
    while (tachRunning) begin
      fanSense[fan] = 1'b1;
      repeat (highCycles) @(negedge clock);
      fanSense[fan] = 1'b0;
      repeat (period - highCycles) @(negedge clock);
    end
  endtask

  task automatic waitWindows(input int windows);
    int seen;
    int waitCycles;
    seen = 0;
    waitCycles = 0;
    while (seen < windows) begin
      if (waitCycles > (windows + 1) * WindowCycles) begin
        reportTimeout("the tach window pulse");
      end
      @(negedge clock);
      waitCycles++;
      if (fanController_inst.windowPulse) begin
        seen++;
      end
    end
  endtask

  task automatic checkResetState();
    fanPkg::fanCsrWord_u readWord;
    csrReadTask(8'd0, readWord);
    compareWord("id word", readWord, makeIdWord());
    for (int fan = 0; fan < FanCount; fan++) begin
      csrReadTask(8'(fan + 1), readWord);
      compareWord($sformatf("fan %0d word", fan), readWord,
                  makeFanWord(7'(FanDefaultDuty), 10'd0));
    end
    csrReadTask(8'(FanCount + 1), readWord);
    compareWord("word past last fan", readWord, '0);
  endtask

  task automatic checkRegisterRules();
    fanPkg::fanCsrWord_u readWord;
    csrWriteTask(8'd1, 32'hffff_ffff);
    csrReadTask(8'd1, readWord);
    compareWord("fan 0 after all-ones write", readWord, makeFanWord(7'h7f, 10'd0));
    // id word and unmapped addresses ignore writes
    csrWriteTask(8'd0, 32'hffff_ffff);
    csrWriteTask(8'(FanCount + 1), 32'hffff_ffff);
    csrWriteTask(8'hff, 32'h0000_0011);
    csrReadTask(8'd0, readWord);
    compareWord("id word after write", readWord, makeIdWord());
    csrReadTask(8'd1, readWord);
    compareWord("fan 0 after stray writes", readWord, makeFanWord(7'h7f, 10'd0));
    csrReadTask(8'd2, readWord);
    compareWord("fan 1 after stray writes", readWord, makeFanWord(7'(FanDefaultDuty), 10'd0));
    csrReadTask(8'(FanCount + 1), readWord);
    compareWord("word past last fan after write", readWord, '0);
    csrWriteTask(8'd1, 32'(FanDefaultDuty));
  endtask

  task automatic measurePwm(input logic [6:0] duty0, input logic [6:0] duty1);
    int         highCount [FanCount];
    logic [6:0] duties [FanCount];
    int         expected;
    duties[0] = duty0;
    duties[1] = duty1;
    csrWriteTask(8'd1, 32'(duty0));
    csrWriteTask(8'd2, 32'(duty1));
    // let the new duty reach the registered output
    repeat (2) @(negedge clock);
    for (int fan = 0; fan < FanCount; fan++) begin
      highCount[fan] = 0;
    end
    repeat (PwmPeriodCycles) begin
      @(negedge clock);
      for (int fan = 0; fan < FanCount; fan++) begin
        if (fanPwm[fan]) begin
          highCount[fan]++;
        end
      end
    end
    for (int fan = 0; fan < FanCount; fan++) begin
      expected = (duties[fan] >= 7'(fanPkg::DutyMax)) ? PwmPeriodCycles
                                                      : int'(duties[fan]) * PrescaleDivider;
      compareCount($sformatf("fan %0d high cycles at duty %0d", fan, duties[fan]),
                   10'(highCount[fan]), 10'(expected));
    end
  endtask

  task automatic checkPwmDuty();
    logic [6:0] randomDuty;
    randomDuty = 7'($urandom % 100);
    measurePwm(7'd0, 7'd25);
    measurePwm(7'd25, 7'd100);
    measurePwm(7'd100, randomDuty);
    measurePwm(randomDuty, 7'd0);
  endtask

  task automatic checkTachCount();
    fanPkg::fanCsrWord_u readWord;
    tachRunning = 1'b1;
    fork
      driveTach(0, 100, 40);
      driveTach(1, 200, 100);
      begin
        // only the second window is whole
        waitWindows(2);
        csrReadTask(8'd1, readWord);
        compareCount("fan 0 pulsesPerWindow", readWord.fanView.pulsesPerWindow,
                     10'(WindowCycles / 100));
        csrReadTask(8'd2, readWord);
        compareCount("fan 1 pulsesPerWindow", readWord.fanView.pulsesPerWindow,
                     10'(WindowCycles / 200));
        tachRunning = 1'b0;
      end
    join
  endtask

  task automatic checkGlitchRejection();
    fanPkg::fanCsrWord_u readWord;
    tachRunning = 1'b1;
    fork
      driveTach(0, 50, 3);
      begin
        waitWindows(2);
        csrReadTask(8'd1, readWord);
        compareCount("fan 0 count with glitches", readWord.fanView.pulsesPerWindow, 10'd0);
        csrReadTask(8'd2, readWord);
        compareCount("fan 1 count when idle", readWord.fanView.pulsesPerWindow, 10'd0);
        tachRunning = 1'b0;
      end
    join
  endtask

  initial begin
    void'($urandom(32'h9b69));
    errorCount = 0;
    timeoutCount = 0;
    tachRunning = 1'b0;
    rstN = 1'b0;
    csrWrite = 1'b0;
    csrRead = 1'b0;
    csrAddress = '0;
    csrWriteData = '0;
    fanSense = '0;
    repeat (5) @(posedge clock);
    @(negedge clock);
    // fans forced on while in reset
    for (int fan = 0; fan < FanCount; fan++) begin
      compareBit($sformatf("fanPwm[%0d] in reset", fan), fanPwm[fan], 1'b1);
    end
    compareBit("csrReadValid in reset", csrReadValid, 1'b0);
    rstN = 1'b1;
    checkResetState();
    checkRegisterRules();
    checkPwmDuty();
    checkTachCount();
    checkGlitchRejection();
    endRun();
  end

endmodule

// File: vlog.f
design/fanPkg.sv
design/fanTimebase.sv
design/fanDebounce.sv
design/fanChannel.sv
design/fanRegisters.sv
design/fanController.sv
dv/fanControllerTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing -Wno-fatal
TOP ?= fanControllerTb
FILELIST ?= vlog.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
